/* Bender.yml */
package:
  name: uart_link

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uartLinePkg.sv
      - uartHostPkg.sv
      - byteFifo.sv
      - uartTx.sv
      - uartRx.sv
      - uartLink.sv
  - target: test
    include_dirs:
      - .
    files:
      - uartLink_tb.sv

/* byteFifo.sv */
module byteFifo #(
    parameter int Depth = 4,
    parameter int Width = 8
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             push,
    input  logic [Width-1:0] pushBeat,
    input  logic             pop,
    output logic [Width-1:0] popBeat,
    output logic             empty,
    output logic             full
);

    localparam int AddrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    logic [Width-1:0] mem [Depth];
    logic [AddrW-1:0] wrPtr;
    logic [AddrW-1:0] rdPtr;
    logic [CntW-1:0]  count;
    logic             doPush;
    logic             doPop;

    assign doPush  = push && !full;
    assign doPop   = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CntW'(Depth));
    assign popBeat = mem[rdPtr];    // show-ahead read

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= (wrPtr == AddrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == AddrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (doPush)
            mem[wrPtr] <= pushBeat;
    end

    pushWhileFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("byteFifo overflow");
    popWhileEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
        else $error("byteFifo underflow");

endmodule

/* uartHostPkg.sv */
package uartHostPkg;

    // byte handed over by the host for transmission
    typedef struct packed {
        logic [7:0] data;
    } txBeat;

    // byte returned to the host, same bit layout as the line frame
    typedef struct packed {
        logic [7:0] data;
        logic       frameErr;
    } rxBeat;

endpackage

/* uartLinePkg.sv */
package uartLinePkg;

    // serializer states, settle adds one idle-high cycle after the stop bit
    typedef enum logic [2:0] {
        txIdle,
        txStartBit,
        txDataBits,
        txStopBit,
        txSettle
    } txState;

    // deserializer states
    typedef enum logic [1:0] {
        rxIdle,
        rxStartChk,     // waiting for mid start bit
        rxDataBits,
        rxStopBit
    } rxState;

    // one frame as rebuilt from the line
    typedef struct packed {
        logic [7:0] data;
        logic       frameErr;   // stop bit sampled low
    } rxFrame;

endpackage

/* uartLink.f */
+incdir+.
uartLinePkg.sv
uartHostPkg.sv
byteFifo.sv
uartTx.sv
uartRx.sv
uartLink.sv
uartLink_tb.sv

/* uartLink.sv */
`include "uart_settings.svh"

module uartLink (
    input  logic               clk,
    input  logic               rstN,
    input  logic               txValid,
    input  uartHostPkg::txBeat txIn,
    output logic               txCredit,
    input  logic               rxd,
    output logic               txd,
    input  logic               rxCredit,
    output logic               rxValid,
    output uartHostPkg::rxBeat rxOut,
    output logic               rxDropped
);

    import uartLinePkg::*;

    localparam int CreditW = `UART_CREDIT_WIDTH;

    logic [7:0]         txPopBeat;
    logic               txEmpty;
    logic               txPop;
    rxFrame             rxPushFrame;
    logic               rxPush;
    logic [8:0]         rxPopBeat;
    logic               rxEmpty;
    logic               rxFull;
    logic               rxPop;
    logic [CreditW-1:0] rxCreditCnt;

    byteFifo #(.Depth(`UART_TX_DEPTH), .Width(8)) i_txFifo (
        .clk(clk), .rstN(rstN),
        .push(txValid), .pushBeat(txIn),
        .pop(txPop), .popBeat(txPopBeat),
        .empty(txEmpty), .full()
    );

    uartTx i_tx (
        .clk(clk), .rstN(rstN),
        .empty(txEmpty), .beat(txPopBeat),
        .pop(txPop), .txd(txd)
    );

    assign txCredit = txPop;    // each freed entry goes back to the host

    uartRx i_rx (
        .clk(clk), .rstN(rstN),
        .rxd(rxd), .push(rxPush), .frame(rxPushFrame)
    );

    assign rxDropped = rxPush && rxFull;

    byteFifo #(.Depth(`UART_RX_DEPTH), .Width(9)) i_rxFifo (
        .clk(clk), .rstN(rstN),
        .push(rxPush && !rxFull), .pushBeat(rxPushFrame),
        .pop(rxPop), .popBeat(rxPopBeat),
        .empty(rxEmpty), .full(rxFull)
    );

    assign rxPop = (rxCreditCnt != '0) && !rxEmpty;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxCreditCnt <= '0;
            rxValid     <= 1'b0;
        end else begin
            rxValid <= rxPop;
            case ({rxCredit, rxPop})
                2'b10:   rxCreditCnt <= rxCreditCnt + 1'b1;
                2'b01:   rxCreditCnt <= rxCreditCnt - 1'b1;
                default: rxCreditCnt <= rxCreditCnt;  // grant and spend cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rxPop)
            rxOut <= rxPopBeat;
    end

    rxCreditOverflow: assert property (@(posedge clk) disable iff (!rstN)
        (rxCredit && !rxPop) |-> (rxCreditCnt != '1))
        else $error("uartLink receive credit counter overflow");

endmodule

/* uartLink_tb.sv */
`include "uart_settings.svh"

module uartLink_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import uartHostPkg::*;

    localparam int Cpb         = `UART_CLKS_PER_BIT;
    localparam int FrameCycles = 10 * Cpb + 3;
    localparam int NumRows     = 6;
    localparam int NumFill     = `UART_RX_DEPTH + 2;

    typedef struct packed {
        logic [63:0] name;
        logic [7:0]  data;
        logic        badStop;   // sent by hand with a low stop bit
        logic [7:0]  expData;
        logic        expErr;
    } stimRow;

    logic       clk, rstN, txValid, txCredit, rxdLine, txd;
    logic       rxCredit, rxValid, rxDropped, useLoop, bangBit;
    txBeat      txIn;
    rxBeat      rxOut, got;
    rxBeat      rxQ[$];
    stimRow     stimTable[NumRows];
    logic [7:0] fill[NumFill];
    logic [9:0] bits;
    int         hostCredits, txPulses, dropCnt, sentCnt, lowLen, numLoop;
    int         errCnt, errBase, passCnt, failCnt;
    string      rowName;

    assign rxdLine = useLoop ? txd : bangBit;

    uartLink i_dut (
        .clk(clk), .rstN(rstN),
        .txValid(txValid), .txIn(txIn), .txCredit(txCredit),
        .rxd(rxdLine), .txd(txd),
        .rxCredit(rxCredit), .rxValid(rxValid), .rxOut(rxOut), .rxDropped(rxDropped)
    );

    always #20 clk = ~clk;

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            if (txCredit) begin
                txPulses++;
                hostCredits++;
            end
            if (rxValid)
                rxQ.push_back(rxOut);
            if (rxDropped)
                dropCnt++;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
            errCnt++;
        end
    endtask

    task automatic timeoutHit(input string what);
        $display("timed out waiting for %s", what);
        $display("Errors found");
        $finish;
    endtask

    task automatic endTest(input string name);
        if (errCnt == errBase) begin
            passCnt++;
            $display("test %s: ok", name);
        end else begin
            failCnt++;
            $display("test %s: failed", name);
        end
        errBase = errCnt;
    endtask

    task automatic checkQuiet();
        checkVal("resetTxd", 1, txd);
        checkVal("resetTxCredit", 0, txCredit);
        checkVal("resetRxValid", 0, rxValid);
        checkVal("resetRxDropped", 0, rxDropped);
    endtask

    task automatic sendByte(input logic [7:0] b);
        int n = 0;
        while (hostCredits <= 0 && n < 4 * FrameCycles) begin
            tick();
            n++;
        end
        if (hostCredits <= 0)
            timeoutHit("a transmit credit");
        txValid   = 1'b1;
        txIn.data = b;
        hostCredits--;
        sentCnt++;
        tick();
        txValid = 1'b0;
    endtask

    task automatic grantRx();
        repeat ($urandom_range(3)) tick();  // random grant delay
        rxCredit = 1'b1;
        tick();
        rxCredit = 1'b0;
    endtask

    task automatic waitBeats(input int n, input string what);
        int k = 0;
        while (rxQ.size() < n && k < (n + 2) * FrameCycles) begin
            tick();
            k++;
        end
        if (rxQ.size() < n)
            timeoutHit(what);
    endtask

    task automatic waitDrops(input int n);
        int k = 0;
        while (dropCnt < n && k < (NumFill + 2) * FrameCycles) begin
            tick();
            k++;
        end
        if (dropCnt < n)
            timeoutHit("dropped frames");
    endtask

    task automatic bangFrame(input logic [7:0] b, input logic badStop);
        logic [9:0] frame;
        frame = {~badStop, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            bangBit = frame[k];
            repeat (Cpb) tick();
        end
        bangBit = 1'b1;
        repeat (2 * Cpb) tick();
    endtask

    // samples txd once per cycle from the first low cycle on
    task automatic captureFrame(output logic [9:0] seen, output int startLen);
        logic [10*Cpb-1:0] smp;
        int n = 0;
        @(negedge clk);
        while (txd !== 1'b0 && n < 4 * FrameCycles) begin
            @(negedge clk);
            n++;
        end
        if (txd !== 1'b0)
            timeoutHit("a start bit on txd");
        for (int k = 0; k < 10 * Cpb; k++) begin
            smp[k] = txd;
            @(negedge clk);
        end
        startLen = 0;
        while (startLen < 10 * Cpb && smp[startLen] == 1'b0)
            startLen++;
        for (int k = 0; k < 10; k++)
            seen[k] = smp[k*Cpb + Cpb/2];   // bit centre
        tick();
    endtask

    initial begin
        clk = 0;
        rstN = 0;
        txValid = 0;
        txIn = '0;
        rxCredit = 0;
        useLoop = 1;
        bangBit = 1;
        hostCredits = `UART_TX_DEPTH;
        txPulses = 0;
        dropCnt = 0;
        sentCnt = 0;
        errCnt = 0;
        errBase = 0;
        passCnt = 0;
        failCnt = 0;
        numLoop = 0;
        lowLen = $urandom(32'h3c060097);
        stimTable[0] = '{"zeros", 8'h00, 1'b0, 8'h00, 1'b0};
        stimTable[1] = '{"ones", 8'hFF, 1'b0, 8'hFF, 1'b0};
        stimTable[2] = '{"alt55", 8'h55, 1'b0, 8'h55, 1'b0};
        stimTable[3] = '{"badStop", 8'h96, 1'b1, 8'h96, 1'b1};
        stimTable[4] = '{"altAA", 8'hAA, 1'b0, 8'hAA, 1'b0};
        stimTable[5] = '{"mix3C", 8'h3C, 1'b0, 8'h3C, 1'b0};

        repeat (8) begin
            @(negedge clk);
            checkQuiet();
        end
        tick();
        rstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkQuiet();
        end
        tick();
        endTest("reset");

        sendByte(8'hA5);    // lsb is 1 so the start bit length is visible
        captureFrame(bits, lowLen);
        checkVal("startLen", Cpb, lowLen);
        checkVal("frameBits", {1'b1, 8'hA5, 1'b0}, bits);
        grantRx();
        waitBeats(1, "the looped shape byte");
        got = rxQ.pop_front();
        checkVal("shapeEcho", {8'hA5, 1'b0}, got);
        endTest("frameShape");

        // loopback rows go out back to back and outnumber the buffer entries
        for (int i = 0; i < NumRows; i++) begin
            if (!stimTable[i].badStop) begin
                sendByte(stimTable[i].data);
                numLoop++;
            end
        end
        repeat (numLoop) grantRx();
        for (int i = 0; i < NumRows; i++) begin
            if (!stimTable[i].badStop) begin
                rowName = $sformatf("%0s", stimTable[i].name);
                waitBeats(1, rowName);
                got = rxQ.pop_front();
                checkVal(rowName, {stimTable[i].expData, stimTable[i].expErr}, got);
                endTest(rowName);
            end
        end
        checkVal("txPulses", sentCnt, txPulses);
        checkVal("hostCredits", `UART_TX_DEPTH, hostCredits);
        checkVal("noDrops", 0, dropCnt);
        endTest("txCredits");

        useLoop = 1'b0;
        for (int i = 0; i < NumRows; i++) begin
            if (stimTable[i].badStop) begin
                rowName = $sformatf("%0s", stimTable[i].name);
                bangFrame(stimTable[i].data, stimTable[i].badStop);
                grantRx();
                waitBeats(1, rowName);
                got = rxQ.pop_front();
                checkVal(rowName, {stimTable[i].expData, stimTable[i].expErr}, got);
                endTest(rowName);
            end
        end
        useLoop = 1'b1;

        // without receive credits the last two frames find the buffer full
        for (int k = 0; k < NumFill; k++) begin
            fill[k] = $urandom;
            sendByte(fill[k]);
        end
        waitDrops(2);
        repeat (2 * Cpb) tick();
        checkVal("heldBack", 0, rxQ.size());
        checkVal("dropCount", 2, dropCnt);
        repeat (NumFill) grantRx();
        waitBeats(`UART_RX_DEPTH, "buffered bytes");
        repeat (FrameCycles) tick();
        checkVal("keptCount", `UART_RX_DEPTH, rxQ.size());
        for (int k = 0; k < `UART_RX_DEPTH; k++) begin
            got = rxQ.pop_front();
            checkVal($sformatf("fill%0d", k), {fill[k], 1'b0}, got);
        end
        checkVal("fillPulses", sentCnt, txPulses);
        endTest("backPressure");

        $display("tests passed: %0d, tests failed: %0d", passCnt, failCnt);
        if (errCnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* uartRx.sv */
`include "uart_settings.svh"

module uartRx (
    input  logic                clk,
    input  logic                rstN,
    input  logic                rxd,
    output logic                push,
    output uartLinePkg::rxFrame frame
);

    import uartLinePkg::*;

    localparam int CntW = (`UART_CLKS_PER_BIT > 1) ? $clog2(`UART_CLKS_PER_BIT) : 1;
    localparam logic [CntW-1:0] LastCnt = CntW'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CntW-1:0] HalfCnt = CntW'(`UART_CLKS_PER_BIT / 2 - 1);

    rxState          state;
    logic [1:0]      syncQ;
    logic            rxS;
    logic            rxPrev;
    logic [CntW-1:0] bitCnt;
    logic [2:0]      bitIdx;
    logic [7:0]      shiftQ;
    logic            fallEdge;
    logic            bitDone;

    assign rxS      = syncQ[1];
    assign fallEdge = rxPrev && !rxS;
    assign bitDone  = (bitCnt == LastCnt);

    // two-flop synchronizer plus edge history, idle line is high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncQ  <= 2'b11;
            rxPrev <= 1'b1;
        end else begin
            syncQ  <= {syncQ[0], rxd};
            rxPrev <= rxS;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= rxIdle;
            bitCnt <= '0;
            bitIdx <= '0;
            push   <= 1'b0;
        end else begin
            push   <= 1'b0;
            bitCnt <= bitDone ? '0 : bitCnt + 1'b1;
            case (state)
                rxIdle: begin
                    bitCnt <= '0;
                    if (fallEdge)
                        state <= rxStartChk;
                end
                rxStartChk: begin
                    if (bitCnt == HalfCnt) begin
                        bitCnt <= '0;   // later samples land on bit centres
                        bitIdx <= '0;
                        state  <= rxS ? rxIdle : rxDataBits;    // high means a glitch
                    end
                end
                rxDataBits: begin
                    if (bitDone) begin
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7)
                            state <= rxStopBit;
                    end
                end
                rxStopBit: begin
                    if (bitDone) begin
                        push  <= 1'b1;
                        state <= rxIdle;
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rxDataBits && bitDone)
            shiftQ <= {rxS, shiftQ[7:1]};   // lsb arrives first
        if (state == rxStopBit && bitDone) begin
            frame.data     <= shiftQ;
            frame.frameErr <= !rxS;
        end
    end

endmodule

/* uartTx.sv */
`include "uart_settings.svh"

module uartTx (
    input  logic               clk,
    input  logic               rstN,
    input  logic               empty,
    input  uartHostPkg::txBeat beat,
    output logic               pop,
    output logic               txd
);

    import uartLinePkg::*;

    localparam int CntW = (`UART_CLKS_PER_BIT > 1) ? $clog2(`UART_CLKS_PER_BIT) : 1;
    localparam logic [CntW-1:0] LastCnt = CntW'(`UART_CLKS_PER_BIT - 1);

    txState          state;
    logic [CntW-1:0] bitCnt;    // cycles within the current bit
    logic [2:0]      bitIdx;
    logic [7:0]      dataQ;
    logic            bitDone;

    assign pop     = (state == txIdle) && !empty;
    assign bitDone = (bitCnt == LastCnt);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= txIdle;
            bitCnt <= '0;
            bitIdx <= '0;
            txd    <= 1'b1;
        end else begin
            bitCnt <= bitDone ? '0 : bitCnt + 1'b1;
            case (state)
                txIdle: begin
                    bitCnt <= '0;
                    if (pop) begin
                        state <= txStartBit;
                        txd   <= 1'b0;      // start bit from the next cycle on
                    end
                end
                txStartBit: begin
                    if (bitDone) begin
                        state  <= txDataBits;
                        bitIdx <= '0;
                        txd    <= dataQ[0];
                    end
                end
                txDataBits: begin
                    if (bitDone) begin
                        if (bitIdx == 3'd7) begin
                            state <= txStopBit;
                            txd   <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txd    <= dataQ[bitIdx + 1'b1];
                        end
                    end
                end
                txStopBit: begin
                    if (bitDone)
                        state <= txSettle;
                end
                txSettle: state <= txIdle;  // one extra high cycle
                default:  state <= txIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            dataQ <= beat.data;
    end

    idleLineHigh: assert property (@(posedge clk) disable iff (!rstN)
        (state == txIdle) |-> txd)
        else $error("uartTx line low while idle");

endmodule

/* uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// serial bit period in clk cycles
`define UART_CLKS_PER_BIT 8

// buffer entries per direction
`define UART_TX_DEPTH 4
`define UART_RX_DEPTH 4

// wide enough to hold a full buffer's worth of credits
`define UART_CREDIT_WIDTH 4

`endif
